// File: sigmoid.f
hdl/sigmoidFmtPkg.sv
hdl/sigmoidCoefPkg.sv
hdl/sigmoidRangeReduce.sv
hdl/sigmoidSegmentCoef.sv
hdl/sigmoidSlopeIntercept.sv
hdl/sigmoidOutputFormat.sv
hdl/sigmoidTop.sv
sim/sigmoidTop_chk.sv
sim/sigmoidTb.sv

// File: run.sh
#!/bin/sh
# Build and run the sigmoid testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sigmoidTb \
	-f sigmoid.f -o sigmoidSim --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/sigmoidSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: sim/sigmoidTb.sv
`timescale 1ns/1ps

module sigmoidTb;
	import sigmoidFmtPkg::*;
	import sigmoidCoefPkg::*;

	logic   clk;
	logic   i_rst;
	logic   i_in_valid;
	sampleT i_x;
	wordT   o_y;
	logic   o_out_valid;

	// words still travelling through the pipeline in arrival order
	wordT expQ [$];
	wordT expWord;
	int   errors;

	sigmoidTop UUT (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_in_valid  (i_in_valid),
		.i_x         (i_x),
		.o_y         (o_y),
		.o_out_valid (o_out_valid)
	);

	always #20 clk = ~clk;

	// expected word straight from the segment tables and packing rule
	function automatic wordT refSigmoid(input sampleT x);
		logic        neg;
		magT         mag;
		segT         seg;
		offsetT      off;
		int          lineVal;
		logic [10:0] field;
		if (int'(x) == -128) begin
			return SPECIAL_WORD;
		end
		neg = x[7];
		mag = magT'(neg ? -int'(x) : int'(x));
		seg = mag[6:4];
		off = mag[3:0];
		lineVal = int'(SLOPE_TABLE[seg]) * int'(off) + int'(INTERCEPT_TABLE[seg]);
		field = {1'b1, lineT'(lineVal)};
		// negative side is the bitwise mirror
		if (neg) begin
			field = ~field;
		end
		return {1'b0, field, neg, 1'b0, LOW_TAG};
	endfunction

	task automatic stopRun();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic sendSample(input sampleT x);
		@(posedge clk);
		i_in_valid <= 1'b1;
		i_x <= x;
		expQ.push_back(refSigmoid(x));
	endtask

	task automatic driveIdle(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			i_in_valid <= 1'b0;
			i_x <= '0;
		end
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (expQ.size() != 0 && cycles < 50) begin
			@(posedge clk);
			cycles++;
		end
		if (expQ.size() != 0) begin
			$display("Error: timed out waiting for %0d pending outputs", expQ.size());
			stopRun();
		end
	endtask

	// count edges from a lone sample to its pulse and make sure no other follows
	task automatic measureSingle(input sampleT x);
		int   edges;
		int   pulses;
		logic seen;
		edges = 0;
		seen = 1'b0;
		sendSample(x);
		while (!seen && edges < 20) begin
			@(posedge clk);
			i_in_valid <= 1'b0;
			edges++;
			@(negedge clk);
			seen = o_out_valid;
		end
		if (!seen) begin
			$display("Error: no output pulse for a single sample within %0d edges", edges);
			stopRun();
		end
		checkValue("output latency", 32'(edges), 32'(PIPE_DEPTH));
		pulses = 1;
		repeat (8) begin
			@(negedge clk);
			if (o_out_valid) begin
				pulses++;
			end
		end
		checkValue("o_out_valid pulses", 32'(pulses), 32'd1);
		waitDrain();
	endtask

	// compare every emerging word against the oldest expectation
	always @(negedge clk) begin
		if (o_out_valid) begin
			if (expQ.size() == 0) begin
				$display("Error: output valid at %0t ns with no sample outstanding", $time);
				stopRun();
			end else begin
				expWord = expQ.pop_front();
				checkValue("o_y", 32'(o_y), 32'(expWord));
			end
		end
	end

	initial begin
		clk = 1'b0;
		i_rst = 1'b1;
		i_in_valid = 1'b0;
		i_x = '0;
		errors = 0;
		void'($urandom(32'hf2d3_5f8c));

		// outputs held at zero through reset
		repeat (9) begin
			@(posedge clk);
			@(negedge clk);
			checkValue("o_out_valid", 32'(o_out_valid), 32'd0);
			checkValue("o_y", 32'(o_y), 32'd0);
		end
		@(posedge clk);
		i_rst <= 1'b0;
		repeat (8) begin
			@(negedge clk);
			checkValue("o_out_valid", 32'(o_out_valid), 32'd0);
			checkValue("o_y", 32'(o_y), 32'd0);
		end

		measureSingle(sampleT'(37));
		measureSingle(sampleT'(-90));

		// every segment from the positive side
		for (int v = 0; v < 128; v++) begin
			sendSample(sampleT'(v));
		end
		driveIdle(1);
		waitDrain();

		for (int v = -1; v >= -127; v--) begin
			sendSample(sampleT'(v));
		end
		driveIdle(1);
		waitDrain();

		// -128 alone and then wedged between ordinary samples
		sendSample(sampleT'(-128));
		driveIdle(2);
		sendSample(sampleT'(5));
		sendSample(sampleT'(-128));
		sendSample(sampleT'(-5));
		sendSample(sampleT'(-128));
		sendSample(sampleT'(127));
		driveIdle(1);
		waitDrain();

		for (int i = 0; i < 500; i++) begin
			if ($urandom() % 4 == 0) begin
				driveIdle(1 + int'($urandom() % 3));
			end
			sendSample(sampleT'($urandom()));
		end
		driveIdle(1);
		waitDrain();
		driveIdle(8);

		if (errors == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stopRun();
		end
	end

endmodule

// File: sim/sigmoidTop_chk.sv
`timescale 1ns/1ps

module sigmoidTopChk (
	input logic                clk,
	input logic                i_rst,
	input logic                i_inValid,
	input sigmoidFmtPkg::wordT i_y,
	input logic                i_outValid
);
	import sigmoidCoefPkg::*;

	// synchronous reset clears the strobe one edge later
	resetQuiet: assert property (@(posedge clk) $past(i_rst) |-> !i_outValid)
		else $error("o_out_valid high during reset");

	// fixed latency, no bubbles lost or added
	validLatency: assert property (@(posedge clk) disable iff (i_rst)
		i_outValid == $past(i_inValid, PIPE_DEPTH))
		else $error("o_out_valid does not follow i_in_valid by the pipeline depth");

	frameBits: assert property (@(posedge clk) disable iff (i_rst)
		i_outValid |-> (!i_y[15] && i_y[0]))
		else $error("o_y frame bits wrong on a valid output");

	// 01 for ordinary words, 10 only in the special word
	tagBits: assert property (@(posedge clk) disable iff (i_rst)
		i_outValid |-> (i_y[2:1] == 2'b01 || i_y[2:1] == 2'b10))
		else $error("o_y tag bits wrong on a valid output");

endmodule

bind sigmoidTop sigmoidTopChk topChk (
	.clk        (clk),
	.i_rst      (i_rst),
	.i_inValid  (i_in_valid),
	.i_y        (o_y),
	.i_outValid (o_out_valid)
);

// File: hdl/sigmoidTop.sv
`timescale 1ns/1ps

module sigmoidTop (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_in_valid,
	input  sigmoidFmtPkg::sampleT  i_x,
	output sigmoidFmtPkg::wordT    o_y,
	output logic                   o_out_valid
);
	import sigmoidFmtPkg::*;

	// stage 2 view of the sample
	logic   s2Valid;
	logic   s2Sign;
	logic   s2Special;
	segT    s2Seg;
	offsetT s2Offset;

	slopeT     slope;
	interceptT intercept;
	lineT      line;

	sigmoidRangeReduce rangeReduce (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_inValid (i_in_valid),
		.i_x       (i_x),
		.o_valid   (s2Valid),
		.o_sign    (s2Sign),
		.o_special (s2Special),
		.o_seg     (s2Seg),
		.o_offset  (s2Offset)
	);

	sigmoidSegmentCoef segmentCoef (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_seg       (s2Seg),
		.o_slope     (slope),
		.o_intercept (intercept)
	);

	// stages 2 to 4
	sigmoidSlopeIntercept slopeIntercept (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_slope     (slope),
		.i_offset    (s2Offset),
		.i_intercept (intercept),
		.o_line      (line)
	);

	sigmoidOutputFormat outputFormat (
		.clk        (clk),
		.i_rst      (i_rst),
		.i_valid    (s2Valid),
		.i_sign     (s2Sign),
		.i_special  (s2Special),
		.i_line     (line),
		.o_y        (o_y),
		.o_outValid (o_out_valid)
	);

endmodule

// File: hdl/sigmoidOutputFormat.sv
`timescale 1ns/1ps

module sigmoidOutputFormat (
	input  logic                 clk,
	input  logic                 i_rst,
	input  logic                 i_valid,
	input  logic                 i_sign,
	input  logic                 i_special,
	input  sigmoidFmtPkg::lineT  i_line,
	output sigmoidFmtPkg::wordT  o_y,
	output logic                 o_outValid
);
	import sigmoidFmtPkg::*;
	import sigmoidCoefPkg::*;

	// range reduction takes two edges and the output register one
	localparam int ALIGN_DEPTH = PIPE_DEPTH - 3;

	logic [ALIGN_DEPTH-1:0] validPipe;
	logic [ALIGN_DEPTH-1:0] signPipe;
	logic [ALIGN_DEPTH-1:0] specialPipe;

	logic alignedSign;
	wordT normalWord;
	wordT word;

	// sideband delay matching the multiply-add
	always_ff @(posedge clk) begin
		if (i_rst) begin
			validPipe <= '0;
			signPipe <= '0;
			specialPipe <= '0;
		end else begin
			validPipe <= {validPipe[ALIGN_DEPTH-2:0], i_valid};
			signPipe <= {signPipe[ALIGN_DEPTH-2:0], i_sign};
			specialPipe <= {specialPipe[ALIGN_DEPTH-2:0], i_special};
		end
	end

	assign alignedSign = signPipe[ALIGN_DEPTH-1];

	// negative side mirrors the value field by inversion
	assign normalWord = {1'b0, {1'b1, i_line} ^ {11{alignedSign}}, alignedSign, 1'b0, LOW_TAG};

	assign word = specialPipe[ALIGN_DEPTH-1] ? SPECIAL_WORD : normalWord;

	// output edge
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_y <= '0;
			o_outValid <= 1'b0;
		end else begin
			// word loads only with a valid result
			if (validPipe[ALIGN_DEPTH-1]) begin
				o_y <= word;
			end
			o_outValid <= validPipe[ALIGN_DEPTH-1];
		end
	end

endmodule

// File: hdl/sigmoidSlopeIntercept.sv
`timescale 1ns/1ps

module sigmoidSlopeIntercept (
	input  logic                      clk,
	input  logic                      i_rst,
	input  sigmoidFmtPkg::slopeT      i_slope,
	input  sigmoidFmtPkg::offsetT     i_offset,
	input  sigmoidFmtPkg::interceptT  i_intercept,
	output sigmoidFmtPkg::lineT       o_line
);
	import sigmoidFmtPkg::*;

	offsetT  pp [4];
	partT    sum01;
	partT    sum23;
	partT    sum01D23;
	partT    sum23D23;
	productT product;
	productT productD34;
	lineT    line;

	// one partial product per slope bit
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			pp[k] = i_offset & {4{i_slope[k]}};
		end
	end

	// pair the partial products, odd one shifted by one
	assign sum01 = partT'(pp[0]) + partT'({pp[1], 1'b0});
	assign sum23 = partT'(pp[2]) + partT'({pp[3], 1'b0});

	// stage 2 -> 3
	always_ff @(posedge clk) begin
		if (i_rst) begin
			sum01D23 <= '0;
			sum23D23 <= '0;
		end else begin
			sum01D23 <= sum01;
			sum23D23 <= sum23;
		end
	end

	// upper pair carries weight four
	assign product = productT'(sum01D23) + productT'({sum23D23, 2'b00});

	// stage 3 -> 4
	always_ff @(posedge clk) begin
		if (i_rst) begin
			productD34 <= '0;
		end else begin
			productD34 <= product;
		end
	end

	// table keeps the sum inside 10 bits
	assign line = lineT'(productD34) + i_intercept;

	// stage 4 -> 5
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_line <= '0;
		end else begin
			o_line <= line;
		end
	end

endmodule

// File: hdl/sigmoidSegmentCoef.sv
`timescale 1ns/1ps

module sigmoidSegmentCoef (
	input  logic                      clk,
	input  logic                      i_rst,
	input  sigmoidFmtPkg::segT        i_seg,
	output sigmoidFmtPkg::slopeT      o_slope,
	output sigmoidFmtPkg::interceptT  o_intercept
);
	import sigmoidFmtPkg::*;
	import sigmoidCoefPkg::*;

	segT segD23;

	// slope is needed right away by the partial products
	assign o_slope = SLOPE_TABLE[i_seg];

	// segment rides along with the partial sums
	always_ff @(posedge clk) begin
		if (i_rst) begin
			segD23 <= '0;
		end else begin
			segD23 <= i_seg;
		end
	end

	// intercept lookup one stage later
	// lands beside the registered product
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_intercept <= '0;
		end else begin
			o_intercept <= INTERCEPT_TABLE[segD23];
		end
	end

endmodule

// File: hdl/sigmoidRangeReduce.sv
`timescale 1ns/1ps

module sigmoidRangeReduce (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_inValid,
	input  sigmoidFmtPkg::sampleT  i_x,
	output logic                   o_valid,
	output logic                   o_sign,
	output logic                   o_special,
	output sigmoidFmtPkg::segT     o_seg,
	output sigmoidFmtPkg::offsetT  o_offset
);
	import sigmoidFmtPkg::*;

	magT    negX;
	logic   validD01;
	sampleT xD01;
	magT    negXD01;

	logic sign;
	magT  mag;
	logic special;

	// negation formed ahead of the first register
	assign negX = magT'(-i_x);

	// stage 0 -> 1
	always_ff @(posedge clk) begin
		if (i_rst) begin
			validD01 <= 1'b0;
			xD01 <= '0;
			negXD01 <= '0;
		end else begin
			validD01 <= i_inValid;
			xD01 <= i_x;
			negXD01 <= negX;
		end
	end

	// pick magnitude by sign
	assign sign = xD01[7];
	assign mag = sign ? negXD01 : magT'(xD01);

	// only -128 keeps bit 7 after negation
	assign special = sign & mag[7];

	// stage 1 -> 2
	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_valid <= 1'b0;
			o_sign <= 1'b0;
			o_special <= 1'b0;
			o_seg <= '0;
			o_offset <= '0;
		end else begin
			o_valid <= validD01;
			o_sign <= sign;
			o_special <= special;
			o_seg <= mag[6:4];
			o_offset <= mag[3:0];
		end
	end

endmodule

// File: hdl/sigmoidCoefPkg.sv
package sigmoidCoefPkg;

	// slope per segment, steepest near zero
	localparam sigmoidFmtPkg::slopeT SLOPE_TABLE [8] = '{
		4'hF,
		4'hE,
		4'hB,
		4'h8,
		4'h6,
		4'h4,
		4'h2,
		4'h1
	};

	// intercept per segment
	localparam sigmoidFmtPkg::interceptT INTERCEPT_TABLE [8] = '{
		10'h003,
		10'h0FD,
		10'h1DE,
		10'h28F,
		10'h30B,
		10'h364,
		10'h3A2,
		10'h3C8
	};

	// edges from input strobe to output strobe
	localparam int PIPE_DEPTH = 6;

endpackage

// File: hdl/sigmoidFmtPkg.sv
package sigmoidFmtPkg;

	// two's complement input sample
	typedef logic signed [7:0] sampleT;

	// magnitude, top bit only set for -128
	typedef logic [7:0] magT;

	// segment index taken from magnitude bits 6..4
	typedef logic [2:0] segT;

	// position inside a segment, magnitude bits 3..0
	typedef logic [3:0] offsetT;

	// per-segment slope
	typedef logic [3:0] slopeT;

	// sum of two adjacent partial products
	typedef logic [5:0] partT;

	// full slope x offset product
	typedef logic [7:0] productT;

	// per-segment intercept
	typedef logic [9:0] interceptT;

	// slope x offset + intercept
	typedef logic [9:0] lineT;

	// packed output word
	typedef logic [15:0] wordT;

	// fixed result for -128
	localparam wordT SPECIAL_WORD = 16'h024D;

	// bits 1..0 of every ordinary word
	localparam logic [1:0] LOW_TAG = 2'b11;

endpackage
